// File: common/fsync_cfg_pkg.sv
package fsync_cfg_pkg;

  // Mesh size, tiles numbered row-major
  parameter int unsigned N_TILES_Y = 2;  // Tile rows
  parameter int unsigned N_TILES_X = 2;  // Tile columns
  parameter int unsigned N_TILES   = N_TILES_Y * N_TILES_X;

  // One tree level per index bit, so level L spans 2^L tiles
  parameter int unsigned TREE_LVLS = $clog2(N_TILES);

  // Field widths of the sync request
  parameter int unsigned LVL_W = 3;  // Barrier level
  parameter int unsigned ID_W  = 4;  // Barrier id

endpackage

// File: common/fsync_msg_pkg.sv
package fsync_msg_pkg;

  // Request travelling up the tree, one per link
  typedef struct packed {
    logic                             valid;  // One-cycle strobe
    logic [fsync_cfg_pkg::LVL_W-1:0]  lvl;    // Target barrier level
    logic [fsync_cfg_pkg::ID_W-1:0]   id;     // Barrier id
  } fsync_req_t;

  // Response travelling down the tree
  // wake and error are pulses and never high together
  typedef struct packed {
    logic wake;   // Barrier reached
    logic error;  // Mismatch or over-height
  } fsync_rsp_t;

endpackage

// File: fsync_tree/fsync_level_stage.sv
`timescale 1ns/100ps

module fsync_level_stage #(
  parameter int unsigned LVL     = 1,  // Level of this stage
  parameter int unsigned N_NODES = 1   // Nodes in this stage
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,

  input  fsync_msg_pkg::fsync_req_t [2*N_NODES-1:0] child_req_i,
  output fsync_msg_pkg::fsync_rsp_t [2*N_NODES-1:0] child_rsp_o,

  output fsync_msg_pkg::fsync_req_t [N_NODES-1:0]   par_req_o,
  input  fsync_msg_pkg::fsync_rsp_t [N_NODES-1:0]   par_rsp_i
);

  // Node count halves per level, so the height follows from both
  localparam int unsigned TREE_LVLS = LVL + $clog2(N_NODES);
  localparam bit          IS_ROOT   = (LVL == TREE_LVLS);

  fsync_msg_pkg::fsync_rsp_t [N_NODES-1:0] par_rsp;

  // Nothing answers from above the root
  assign par_rsp = IS_ROOT ? '0 : par_rsp_i;

  for (genvar n = 0; n < N_NODES; n++) begin : gen_node
    fsync_node #(
      .LVL     ( LVL     ),
      .IS_ROOT ( IS_ROOT )
    ) i_node (
      .clk_i                             ,
      .rst_n_i                           ,
      .left_req_i  ( child_req_i[2*n]   ),
      .right_req_i ( child_req_i[2*n+1] ),
      .left_rsp_o  ( child_rsp_o[2*n]   ),
      .right_rsp_o ( child_rsp_o[2*n+1] ),
      .par_req_o   ( par_req_o[n]       ),
      .par_rsp_i   ( par_rsp[n]         )
    );
  end

endmodule

// File: fsync_tree/fsync_node.sv
`timescale 1ns/100ps

module fsync_node #(
  parameter int unsigned LVL     = 1,     // Level this node decides
  parameter bit          IS_ROOT = 1'b0   // Top of the tree
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  input  fsync_msg_pkg::fsync_req_t  left_req_i,
  input  fsync_msg_pkg::fsync_req_t  right_req_i,
  output fsync_msg_pkg::fsync_rsp_t  left_rsp_o,
  output fsync_msg_pkg::fsync_rsp_t  right_rsp_o,

  output fsync_msg_pkg::fsync_req_t  par_req_o,
  input  fsync_msg_pkg::fsync_rsp_t  par_rsp_i
);

  fsync_msg_pkg::fsync_req_t left_q;     // Pending slot, valid marks it full
  fsync_msg_pkg::fsync_req_t right_q;
  fsync_msg_pkg::fsync_req_t par_req_q;
  fsync_msg_pkg::fsync_rsp_t rsp_q;
  logic                      fwd_q;      // Combined request sent up, waiting

  logic both;
  logic match;
  logic above;
  logic go_up;
  logic wake_dn;
  logic err_dn;
  logic rsp_in;
  logic clear;

  assign both  = left_q.valid && right_q.valid && !fwd_q;
  assign match = (left_q.lvl == right_q.lvl) && (left_q.id == right_q.id);
  assign above = left_q.lvl > LVL;  // Group extends past this node

  assign go_up   = both && match && above && !IS_ROOT;
  assign wake_dn = both && match && !above;
  assign err_dn  = both && (!match || (above && IS_ROOT));

  assign rsp_in = par_rsp_i.wake || par_rsp_i.error;
  assign clear  = wake_dn || err_dn || rsp_in;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      left_q.valid    <= 1'b0;
      right_q.valid   <= 1'b0;
      par_req_q.valid <= 1'b0;
      rsp_q           <= '0;
      fwd_q           <= 1'b0;
    end else begin
      if (left_req_i.valid) begin
        left_q <= left_req_i;
      end else if (clear) begin
        left_q.valid <= 1'b0;
      end

      if (right_req_i.valid) begin
        right_q <= right_req_i;
      end else if (clear) begin
        right_q.valid <= 1'b0;
      end

      // Own decision and relay from above are exclusive through fwd_q
      rsp_q.wake  <= wake_dn || par_rsp_i.wake;
      rsp_q.error <= err_dn || par_rsp_i.error;

      par_req_q.valid <= go_up;
      par_req_q.lvl   <= left_q.lvl;
      par_req_q.id    <= left_q.id;

      if (rsp_in) begin
        fwd_q <= 1'b0;
      end else if (go_up) begin
        fwd_q <= 1'b1;
      end
    end
  end

  assign left_rsp_o  = rsp_q;
  assign right_rsp_o = rsp_q;
  assign par_req_o   = par_req_q;

  // Children hold off until their previous request is answered
  a_left_no_restrobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    left_req_i.valid |-> !left_q.valid);
  a_right_no_restrobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    right_req_i.valid |-> !right_q.valid);

  // Parent only answers what this node sent up
  a_par_rsp_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_in |-> fwd_q);

  a_rsp_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(rsp_q.wake && rsp_q.error));

endmodule

// File: project.f
common/fsync_cfg_pkg.sv
common/fsync_msg_pkg.sv
fsync_tree/fsync_node.sv
fsync_tree/fsync_level_stage.sv
src/fsync_tile_port.sv
src/fsync_mesh_top.sv
test/tb_fsync_mesh.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fsync_mesh \
  -f project.f -o sim_fsync || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_fsync > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -qF '*** TEST PASSED ***' sim.log && echo "Simulation passed" || {
  echo "Simulation failed"; exit 1; }

// File: src/fsync_mesh_top.sv
`timescale 1ns/100ps

module fsync_mesh_top #(
  parameter int unsigned N_TILES_Y = fsync_cfg_pkg::N_TILES_Y,  // Tile rows
  parameter int unsigned N_TILES_X = fsync_cfg_pkg::N_TILES_X   // Tile columns
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  input  logic                             req_valid_i [N_TILES_Y*N_TILES_X],
  input  logic [fsync_cfg_pkg::LVL_W-1:0]  req_lvl_i   [N_TILES_Y*N_TILES_X],
  input  logic [fsync_cfg_pkg::ID_W-1:0]   req_id_i    [N_TILES_Y*N_TILES_X],

  output logic                             wake_o      [N_TILES_Y*N_TILES_X],
  output logic                             error_o     [N_TILES_Y*N_TILES_X]
);

  localparam int unsigned N_TILES   = N_TILES_Y * N_TILES_X;
  localparam int unsigned TREE_LVLS = $clog2(N_TILES);

  // All tree links in one array: tile links first, then each level's
  // parent links, ending with the single link above the root
  fsync_msg_pkg::fsync_req_t [2*N_TILES-2:0] link_req;
  fsync_msg_pkg::fsync_rsp_t [2*N_TILES-2:0] link_rsp;

  assign link_rsp[2*N_TILES-2] = '0;  // Above the root

  for (genvar i = 0; i < N_TILES_Y; i++) begin : gen_y_tile
    for (genvar j = 0; j < N_TILES_X; j++) begin : gen_x_tile
      fsync_tile_port i_tile_port (
        .clk_i                                       ,
        .rst_n_i                                     ,
        .req_valid_i ( req_valid_i[i*N_TILES_X+j]   ),
        .req_lvl_i   ( req_lvl_i[i*N_TILES_X+j]     ),
        .req_id_i    ( req_id_i[i*N_TILES_X+j]      ),
        .up_req_o    ( link_req[i*N_TILES_X+j]      ),
        .dn_rsp_i    ( link_rsp[i*N_TILES_X+j]      ),
        .wake_o      ( wake_o[i*N_TILES_X+j]        ),
        .error_o     ( error_o[i*N_TILES_X+j]       )
      );
    end
  end

  // Level k pairs tiles differing in index bit k-1
  for (genvar k = 1; k <= TREE_LVLS; k++) begin : gen_lvl
    localparam int unsigned N_NODES = N_TILES >> k;
    localparam int unsigned BASE    = 2*N_TILES - 2*(N_TILES >> (k-1));  // First child link

    fsync_level_stage #(
      .LVL     ( k       ),
      .N_NODES ( N_NODES )
    ) i_level_stage (
      .clk_i                                                 ,
      .rst_n_i                                               ,
      .child_req_i ( link_req[BASE +: 2*N_NODES]            ),
      .child_rsp_o ( link_rsp[BASE +: 2*N_NODES]            ),
      .par_req_o   ( link_req[BASE + 2*N_NODES +: N_NODES]  ),
      .par_rsp_i   ( link_rsp[BASE + 2*N_NODES +: N_NODES]  )
    );
  end

endmodule

// File: src/fsync_tile_port.sv
`timescale 1ns/100ps

module fsync_tile_port (
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  input  logic                             req_valid_i,
  input  logic [fsync_cfg_pkg::LVL_W-1:0]  req_lvl_i,
  input  logic [fsync_cfg_pkg::ID_W-1:0]   req_id_i,

  output fsync_msg_pkg::fsync_req_t        up_req_o,
  input  fsync_msg_pkg::fsync_rsp_t        dn_rsp_i,

  output logic                             wake_o,
  output logic                             error_o
);

  fsync_msg_pkg::fsync_req_t up_req_q;
  logic                      waiting_q;  // Request in flight
  logic                      reject_q;   // Rejected strobe, beside up_req_q
  logic                      wake_q;
  logic                      error_q;

  logic rsp_in;
  logic accept;
  logic reject;

  assign rsp_in = dn_rsp_i.wake || dn_rsp_i.error;

  // The wait ends on the edge its response is registered,
  // so a strobe on that same edge starts a fresh request
  assign accept = req_valid_i && (req_lvl_i != '0) && (!waiting_q || rsp_in);
  assign reject = req_valid_i && !accept;  // Level 0 or repeat while waiting

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      up_req_q.valid <= 1'b0;
      waiting_q      <= 1'b0;
      reject_q       <= 1'b0;
      wake_q         <= 1'b0;
      error_q        <= 1'b0;
    end else begin
      up_req_q.valid <= accept;
      up_req_q.lvl   <= req_lvl_i;
      up_req_q.id    <= req_id_i;
      reject_q       <= reject;

      if (accept) begin
        waiting_q <= 1'b1;
      end else if (rsp_in) begin
        waiting_q <= 1'b0;
      end

      wake_q  <= dn_rsp_i.wake;
      error_q <= dn_rsp_i.error || reject_q;  // Local rejects share the error pulse
    end
  end

  assign up_req_o = up_req_q;
  assign wake_o   = wake_q;
  assign error_o  = error_q;

  // Tree answers only requests this port has sent
  a_rsp_while_waiting: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_in |-> waiting_q);

endmodule

// File: test/fsync_stim.txt
# issue_cycle tile level id(hex) expected(wake/error/none) response_cycle
# A cycle is the edge that samples the request; level L answers 3L cycles after the last one
0  0 1 5 wake  5
2  1 1 5 wake  5
# Level 2 across the whole mesh
10 0 2 9 wake  19
11 1 2 9 wake  19
11 2 2 9 wake  19
13 3 2 9 wake  19
# Id mismatch between tiles 2 and 3
25 2 1 3 error 30
27 3 1 4 error 30
# Above the tree height
35 0 3 7 error 43
35 1 3 7 error 43
36 2 3 7 error 43
37 3 3 7 error 43
# Tile port rejections
50 1 0 2 error 51
52 3 0 2 error 53
55 2 1 6 wake  63
57 2 1 6 error 58
60 3 1 6 wake  63
# Two level 1 groups in flight together
70 0 1 1 wake  75
71 2 1 2 wake  77
72 1 1 1 wake  75
74 3 1 2 wake  77

// File: test/tb_fsync_mesh.sv
`timescale 1ns/100ps

module tb_fsync_mesh;

  localparam int unsigned N_TILES = fsync_cfg_pkg::N_TILES;
  localparam int unsigned LVL_W   = fsync_cfg_pkg::LVL_W;
  localparam int unsigned ID_W    = fsync_cfg_pkg::ID_W;
  localparam int unsigned MAX_CYC = 256;  // Table depth in cycles
  localparam int unsigned DRAIN   = 10;   // Quiet cycles checked after the last response

  logic              clk;
  logic              rst_n;
  logic              req_valid [N_TILES];
  logic [LVL_W-1:0]  req_lvl   [N_TILES];
  logic [ID_W-1:0]   req_id    [N_TILES];
  logic              wake      [N_TILES];
  logic              error     [N_TILES];

  // Drive and expect tables, indexed by cycle and tile
  bit                drv_valid [MAX_CYC][N_TILES];
  bit [LVL_W-1:0]    drv_lvl   [MAX_CYC][N_TILES];
  bit [ID_W-1:0]     drv_id    [MAX_CYC][N_TILES];
  bit                exp_wake  [MAX_CYC][N_TILES];
  bit                exp_error [MAX_CYC][N_TILES];

  int unsigned last_cyc;      // Latest issue or response cycle in the file
  bit          stim_loaded;
  int          n_checks;
  int          n_errors;
  int unsigned gap;           // Idle cycles before cycle 0

  fsync_mesh_top UUT (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .req_valid_i ( req_valid ),
    .req_lvl_i   ( req_lvl   ),
    .req_id_i    ( req_id    ),
    .wake_o      ( wake      ),
    .error_o     ( error     )
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;  // 20 ns period

  task automatic compare_bit(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR %0t ns: %s, got %0b expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic load_stimulus(output bit ok);
    int          fd;
    int          n_fields;
    string       line;
    int unsigned iss;
    int unsigned tile;
    int unsigned lvl;
    int unsigned id;
    int unsigned rsp;
    logic [63:0] kind;
    bit          bad;
    int          n_lines;
    bad     = 1'b0;
    n_lines = 0;
    fd = $fopen("test/fsync_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/fsync_stim.txt");
      bad = 1'b1;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n_fields = $sscanf(line, "%d %d %d %h %s %d", iss, tile, lvl, id, kind, rsp);
        if (n_fields == 6) begin  // Comment and blank lines fall through
          if (tile >= N_TILES || iss + DRAIN + 2 > MAX_CYC || rsp + DRAIN + 2 > MAX_CYC) begin
            $display("Stimulus line out of range: %s", line);
            bad = 1'b1;
          end else begin
            drv_valid[iss][tile] = 1'b1;
            drv_lvl[iss][tile]   = lvl[LVL_W-1:0];
            drv_id[iss][tile]    = id[ID_W-1:0];
            if (kind == 64'("wake")) begin
              exp_wake[rsp][tile] = 1'b1;
            end else if (kind == 64'("error")) begin
              exp_error[rsp][tile] = 1'b1;
            end else if (kind != 64'("none")) begin
              $display("Unknown response kind in stimulus line: %s", line);
              bad = 1'b1;
            end
            if (iss > last_cyc) last_cyc = iss;
            if (rsp > last_cyc) last_cyc = rsp;
            n_lines++;
          end
        end
      end
      $fclose(fd);
      if (n_lines == 0) begin
        $display("No stimulus lines found in test/fsync_stim.txt");
      end
    end
    ok = !bad && (n_lines > 0);
  endtask

  task automatic apply_inputs(input int unsigned cyc);
    for (int t = 0; t < N_TILES; t++) begin
      req_valid[t] = drv_valid[cyc][t];
      req_lvl[t]   = drv_lvl[cyc][t];
      req_id[t]    = drv_id[cyc][t];
    end
  endtask

  // Every tile output is checked every cycle, so silence is checked too
  task automatic check_outputs(input int unsigned cyc);
    for (int t = 0; t < N_TILES; t++) begin
      compare_bit(wake[t], exp_wake[cyc][t],
                  $sformatf("wake_o of tile %0d at cycle %0d", t, cyc));
      compare_bit(error[t], exp_error[cyc][t],
                  $sformatf("error_o of tile %0d at cycle %0d", t, cyc));
    end
  endtask

  initial begin
    bit          ok;
    int unsigned cyc;
    rst_n       = 1'b0;
    stim_loaded = 1'b0;
    last_cyc    = 0;
    n_checks    = 0;
    n_errors    = 0;
    for (int t = 0; t < N_TILES; t++) begin
      req_valid[t] = 1'b0;
      req_lvl[t]   = '0;
      req_id[t]    = '0;
    end
    void'($urandom(91385));
    gap = $urandom_range(7, 0);
    load_stimulus(ok);
    stim_loaded = 1'b1;
    if (!ok) begin
      $display("Stimulus could not be used, run aborted");
      $display("*** TEST FAILED ***");
    end else begin
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
      apply_inputs(0);  // Sampled by the edge of cycle 0
      for (cyc = 0; cyc <= last_cyc + DRAIN; cyc++) begin
        @(posedge clk);
        #2;
        check_outputs(cyc);
        apply_inputs(cyc + 1);
      end
      $display("Run done after %0d idle cycles: %0d checks, %0d errors",
               gap, n_checks, n_errors);
      if (n_errors == 0) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
    end
    $finish;
  end

  // Limit scales with the stimulus length
  initial begin
    wait (stim_loaded);
    #((last_cyc + 50) * 20);
    $display("Watchdog expired, the run did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
